//--- Bender.yml
package:
  name: array_ctl

sources:
  - files:
      - logic/regmap_pkg.sv
      - logic/array_pkg.sv
      - logic/dual_port_ram.sv
      - logic/param_controller.sv
      - logic/delay_mirror.sv
      - logic/array_ctl_top.sv
  - target: simulation
    files:
      - tests/tb_array_ctl.sv

//--- logic/array_ctl_top.sv
// Array control top that splits the CPU bus over the register and delay memories
`default_nettype none
`timescale 1ns/1ps

module array_ctl_top import regmap_pkg::*, array_pkg::*; (
  input  logic        CLK,
  input  logic        reset,
  input  logic        thermo,
  input  logic        bus_en,
  input  logic        bus_we,
  input  bus_addr_t   bus_addr,
  input  word_t       bus_wdata,
  output word_t       bus_rdata,
  output logic        force_fan,
  output logic        op_mode,
  output logic        stm_gain_mode,
  output logic        legacy_mode,
  output word_t       cycle_m,
  output logic [31:0] freq_div_m,
  output word_t       cycle_s,
  output cycle_t      step_s,
  output word_t       cycle_stm,
  output logic [31:0] freq_div_stm,
  output logic [31:0] sound_speed,
  output logic [63:0] ecat_sync_time,
  output logic        sync_set,
  output cycle_t      cycle [num_trans],
  output delay_t      delay_m [num_trans]
);

  logic      ctl_en;
  logic      dly_en;
  ram_addr_t ram_addr;
  logic      ram_we;
  word_t     ram_wdata;
  word_t     ram_rdata;
  word_t     ctl_reg;

  assign ctl_en = bus_en & ~bus_addr[bus_dly_sel_bit];
  assign dly_en = bus_en & bus_addr[bus_dly_sel_bit];

  assign legacy_mode   = ctl_reg[ctl_legacy_mode_bit];
  assign force_fan     = ctl_reg[ctl_force_fan_bit];
  assign op_mode       = ctl_reg[ctl_op_mode_bit];
  assign stm_gain_mode = ctl_reg[ctl_stm_gain_mode_bit];

  // Port A for the CPU, port B for the controller
  dual_port_ram #(
    .addr_width($bits(ram_addr_t))
  ) u_ctl_ram (
    .CLK    (CLK),
    .en_a   (ctl_en),
    .we_a   (bus_we),
    .addr_a (ram_addr_t'(bus_addr[$bits(ram_addr_t)-1:0])),
    .wdata_a(bus_wdata),
    .rdata_a(bus_rdata),
    .en_b   (1'b1),
    .we_b   (ram_we),
    .addr_b (ram_addr),
    .wdata_b(ram_wdata),
    .rdata_b(ram_rdata)
  );

  param_controller u_ctl (
    .CLK           (CLK),
    .reset         (reset),
    .thermo        (thermo),
    .ram_addr      (ram_addr),
    .ram_we        (ram_we),
    .ram_wdata     (ram_wdata),
    .ram_rdata     (ram_rdata),
    .ctl_reg       (ctl_reg),
    .cycle_m       (cycle_m),
    .freq_div_m    (freq_div_m),
    .cycle_s       (cycle_s),
    .step_s        (step_s),
    .cycle_stm     (cycle_stm),
    .freq_div_stm  (freq_div_stm),
    .sound_speed   (sound_speed),
    .ecat_sync_time(ecat_sync_time),
    .cycle         (cycle),
    .sync_set      (sync_set)
  );

  delay_mirror u_dly (
    .CLK    (CLK),
    .reset  (reset),
    .wr_en  (dly_en & bus_we),
    .wr_addr(trans_idx_t'(bus_addr[$bits(trans_idx_t)-1:0])),
    .wr_data(bus_wdata),
    .delay_m(delay_m)
  );

endmodule

`default_nettype wire

//--- logic/array_pkg.sv
// Array package with transducer count and the per-transducer value widths
`default_nettype none

package array_pkg;

  localparam int num_trans = 16;

  typedef logic [$clog2(num_trans)-1:0] trans_idx_t;

  // Carrier cycle, also the width of the silencer step
  typedef logic [12:0] cycle_t;

  typedef logic [15:0] delay_t;

endpackage

`default_nettype wire

//--- logic/delay_mirror.sv
// Delay mirror that holds the delay RAM and scans it into the delay output array
`default_nettype none
`timescale 1ns/1ps

module delay_mirror import regmap_pkg::*, array_pkg::*; (
  input  logic       CLK,
  input  logic       reset,
  input  logic       wr_en,
  input  trans_idx_t wr_addr,
  input  word_t      wr_data,
  output delay_t     delay_m [num_trans]
);

  trans_idx_t rd_idx;   // Slot requested from the RAM
  trans_idx_t set_idx;  // Slot that takes rd_data, lags by the read latency
  word_t      rd_data;

  function automatic trans_idx_t next_idx(input trans_idx_t idx);
    return (idx == trans_idx_t'(num_trans - 1)) ? '0 : idx + 1'b1;
  endfunction

  dual_port_ram #(
    .addr_width($bits(trans_idx_t))
  ) u_dly_ram (
    .CLK    (CLK),
    .en_a   (wr_en),
    .we_a   (wr_en),
    .addr_a (wr_addr),
    .wdata_a(wr_data),
    .rdata_a(),
    .en_b   (1'b1),
    .we_b   (1'b0),
    .addr_b (rd_idx),
    .wdata_b('0),
    .rdata_b(rd_data)
  );

  always_ff @(posedge CLK) begin
    if (reset) begin
      rd_idx  <= '0;
      set_idx <= trans_idx_t'(num_trans - ram_rd_latency);
      for (int i = 0; i < num_trans; i++) begin
        delay_m[i] <= '0;
      end
    end else begin
      rd_idx           <= next_idx(rd_idx);
      set_idx          <= next_idx(set_idx);
      delay_m[set_idx] <= delay_t'(rd_data);
    end
  end

  assert property (@(posedge CLK) disable iff (reset)
    ((int'(rd_idx) + num_trans - int'(set_idx)) % num_trans) == ram_rd_latency)
    else $error("Delay scan indices out of step with the RAM latency");

endmodule

`default_nettype wire

//--- logic/dual_port_ram.sv
// True dual-port RAM with a registered address and registered output per port
`default_nettype none
`timescale 1ns/1ps

module dual_port_ram import regmap_pkg::*; #(
  parameter int addr_width = 9
) (
  input  logic                  CLK,
  input  logic                  en_a,
  input  logic                  we_a,
  input  logic [addr_width-1:0] addr_a,
  input  word_t                 wdata_a,
  output word_t                 rdata_a,
  input  logic                  en_b,
  input  logic                  we_b,
  input  logic [addr_width-1:0] addr_b,
  input  word_t                 wdata_b,
  output word_t                 rdata_b
);

  word_t                 mem [2**addr_width];
  logic [addr_width-1:0] addr_a_q;
  logic [addr_width-1:0] addr_b_q;

  always_ff @(posedge CLK) begin
    if (en_a) begin
      if (we_a) begin
        mem[addr_a] <= wdata_a;
      end
      addr_a_q <= addr_a;
    end
    if (en_b) begin
      if (we_b) begin
        mem[addr_b] <= wdata_b;  // Later write, so port B wins a collision
      end
      addr_b_q <= addr_b;
    end
    rdata_a <= mem[addr_a_q];
    rdata_b <= mem[addr_b_q];
  end

endmodule

`default_nettype wire

//--- logic/param_controller.sv
// Parameter controller that refreshes settings, writes status and runs the sync sequence
`default_nettype none
`timescale 1ns/1ps

module param_controller import regmap_pkg::*, array_pkg::*; (
  input  logic        CLK,
  input  logic        reset,
  input  logic        thermo,
  output ram_addr_t   ram_addr,
  output logic        ram_we,
  output word_t       ram_wdata,
  input  word_t       ram_rdata,
  output word_t       ctl_reg,
  output word_t       cycle_m,
  output logic [31:0] freq_div_m,
  output word_t       cycle_s,
  output cycle_t      step_s,
  output word_t       cycle_stm,
  output logic [31:0] freq_div_stm,
  output logic [31:0] sound_speed,
  output logic [63:0] ecat_sync_time,
  output cycle_t      cycle [num_trans],
  output logic        sync_set
);

  // Each state requests one address and takes the data requested three states before
  typedef enum logic [4:0] {
    st_req_wr_ver,
    st_req_rd_ctl,
    st_rejoin_req_wr_info,
    st_rejoin_req_mod_cycle,
    st_rd_ctl_req_mod_div_0,
    st_wr_info_req_mod_div_1,
    st_rd_mod_cycle_req_silent_cycle,
    st_rd_mod_div_0_req_silent_step,
    st_rd_mod_div_1_req_stm_cycle,
    st_rd_silent_cycle_req_stm_div_0,
    st_rd_silent_step_req_stm_div_1,
    st_rd_stm_cycle_req_speed_0,
    st_rd_stm_div_0_req_speed_1,
    st_rd_stm_div_1_req_ctl,
    st_rd_speed_0_req_wr_info,
    st_rd_speed_1_req_mod_cycle,
    st_req_sync_0,
    st_req_sync_1,
    st_req_sync_2,
    st_req_sync_3_rd_sync_0,
    st_req_cycle_0_rd_sync_1,
    st_req_cycle_1_rd_sync_2,
    st_req_cycle_2_rd_sync_3,
    st_rd_cycle
  } state_t;

  state_t     state;
  trans_idx_t set_cnt;  // Cycle table slot being stored

  always_ff @(posedge CLK) begin
    if (reset) begin
      state          <= st_req_wr_ver;
      ram_addr       <= '0;
      ram_we         <= 1'b0;
      ram_wdata      <= '0;
      ctl_reg        <= '0;
      cycle_m        <= '0;
      freq_div_m     <= '0;
      cycle_s        <= '0;
      step_s         <= '0;
      cycle_stm      <= '0;
      freq_div_stm   <= '0;
      sound_speed    <= '0;
      ecat_sync_time <= '0;
      sync_set       <= 1'b0;
      set_cnt        <= '0;
      for (int i = 0; i < num_trans; i++) begin
        cycle[i] <= '0;
      end
    end else begin
      sync_set <= 1'b0;
      case (state)
        // ##################################################
        // Start up and rejoin
        st_req_wr_ver: begin
          ram_we    <= 1'b1;
          ram_addr  <= addr_version;
          ram_wdata <= version_word;
          state     <= st_req_rd_ctl;
        end
        st_req_rd_ctl: begin
          ram_we   <= 1'b0;
          ram_addr <= addr_ctl_reg;
          state    <= st_rejoin_req_wr_info;
        end
        st_rejoin_req_wr_info: begin
          ram_we    <= 1'b1;
          ram_addr  <= addr_fpga_info;
          ram_wdata <= word_t'({15'd0, thermo});
          state     <= st_rejoin_req_mod_cycle;
        end
        st_rejoin_req_mod_cycle: begin
          ram_we   <= 1'b0;
          ram_addr <= addr_mod_cycle;
          state    <= st_rd_ctl_req_mod_div_0;
        end
        // ##################################################
        // Run loop, twelve states
        st_rd_ctl_req_mod_div_0: begin
          ctl_reg <= ram_rdata;
          if (ram_rdata[ctl_sync_bit]) begin
            ram_we    <= 1'b1;  // Write back with sync bit cleared
            ram_addr  <= addr_ctl_reg;
            ram_wdata <= ram_rdata & ~(word_t'(1) << ctl_sync_bit);
            state     <= st_req_sync_0;
          end else begin
            ram_addr <= addr_mod_freq_div_0;
            state    <= st_wr_info_req_mod_div_1;
          end
        end
        st_wr_info_req_mod_div_1: begin
          ram_addr <= addr_mod_freq_div_1;
          state    <= st_rd_mod_cycle_req_silent_cycle;
        end
        st_rd_mod_cycle_req_silent_cycle: begin
          ram_addr <= addr_silent_cycle;
          cycle_m  <= ram_rdata;
          state    <= st_rd_mod_div_0_req_silent_step;
        end
        st_rd_mod_div_0_req_silent_step: begin
          ram_addr         <= addr_silent_step;
          freq_div_m[15:0] <= ram_rdata;
          state            <= st_rd_mod_div_1_req_stm_cycle;
        end
        st_rd_mod_div_1_req_stm_cycle: begin
          ram_addr          <= addr_stm_cycle;
          freq_div_m[31:16] <= ram_rdata;
          state             <= st_rd_silent_cycle_req_stm_div_0;
        end
        st_rd_silent_cycle_req_stm_div_0: begin
          ram_addr <= addr_stm_freq_div_0;
          cycle_s  <= ram_rdata;
          state    <= st_rd_silent_step_req_stm_div_1;
        end
        st_rd_silent_step_req_stm_div_1: begin
          ram_addr <= addr_stm_freq_div_1;
          step_s   <= ram_rdata[$bits(cycle_t)-1:0];
          state    <= st_rd_stm_cycle_req_speed_0;
        end
        st_rd_stm_cycle_req_speed_0: begin
          ram_addr  <= addr_sound_speed_0;
          cycle_stm <= ram_rdata;
          state     <= st_rd_stm_div_0_req_speed_1;
        end
        st_rd_stm_div_0_req_speed_1: begin
          ram_addr           <= addr_sound_speed_1;
          freq_div_stm[15:0] <= ram_rdata;
          state              <= st_rd_stm_div_1_req_ctl;
        end
        st_rd_stm_div_1_req_ctl: begin
          ram_addr            <= addr_ctl_reg;
          freq_div_stm[31:16] <= ram_rdata;
          state               <= st_rd_speed_0_req_wr_info;
        end
        st_rd_speed_0_req_wr_info: begin
          ram_we            <= 1'b1;
          ram_addr          <= addr_fpga_info;
          ram_wdata         <= word_t'({15'd0, thermo});
          sound_speed[15:0] <= ram_rdata;
          state             <= st_rd_speed_1_req_mod_cycle;
        end
        st_rd_speed_1_req_mod_cycle: begin
          ram_we             <= 1'b0;
          ram_addr           <= addr_mod_cycle;
          sound_speed[31:16] <= ram_rdata;
          state              <= st_rd_ctl_req_mod_div_0;
        end
        // ##################################################
        // Sync sequence
        st_req_sync_0: begin
          ram_we   <= 1'b0;
          ram_addr <= addr_ec_sync_time_0;
          state    <= st_req_sync_1;
        end
        st_req_sync_1: begin
          ram_addr <= addr_ec_sync_time_1;
          state    <= st_req_sync_2;
        end
        st_req_sync_2: begin
          ram_addr <= addr_ec_sync_time_2;
          state    <= st_req_sync_3_rd_sync_0;
        end
        st_req_sync_3_rd_sync_0: begin
          ram_addr             <= addr_ec_sync_time_3;
          ecat_sync_time[15:0] <= ram_rdata;
          state                <= st_req_cycle_0_rd_sync_1;
        end
        st_req_cycle_0_rd_sync_1: begin
          ram_addr              <= addr_cycle_base;
          ecat_sync_time[31:16] <= ram_rdata;
          state                 <= st_req_cycle_1_rd_sync_2;
        end
        st_req_cycle_1_rd_sync_2: begin
          ram_addr              <= ram_addr_t'(ram_addr + 1'b1);
          ecat_sync_time[47:32] <= ram_rdata;
          state                 <= st_req_cycle_2_rd_sync_3;
        end
        st_req_cycle_2_rd_sync_3: begin
          ram_addr              <= ram_addr_t'(ram_addr + 1'b1);
          ecat_sync_time[63:48] <= ram_rdata;
          set_cnt               <= '0;
          state                 <= st_rd_cycle;
        end
        st_rd_cycle: begin
          cycle[set_cnt] <= ram_rdata[$bits(cycle_t)-1:0];
          if (set_cnt == trans_idx_t'(num_trans - 1)) begin
            ram_addr <= addr_ctl_reg;  // Refetch for the loop after rejoin
            sync_set <= 1'b1;
            state    <= st_rejoin_req_wr_info;
          end else begin
            ram_addr <= ram_addr_t'(ram_addr + 1'b1);
            set_cnt  <= set_cnt + 1'b1;
          end
        end
        default: state <= st_req_wr_ver;
      endcase
    end
  end

  assert property (@(posedge CLK) disable iff (reset) sync_set |=> !sync_set)
    else $error("sync_set held for more than one cycle");

  // Writes only follow the version, status and sync clear requests
  assert property (@(posedge CLK) disable iff (reset)
    ram_we |-> $past(state) inside {st_req_wr_ver, st_rejoin_req_wr_info,
                                    st_rd_speed_0_req_wr_info, st_rd_ctl_req_mod_div_0})
    else $error("Register RAM written from an unexpected state");

endmodule

`default_nettype wire

//--- logic/regmap_pkg.sv
// Register map package with bus widths, register addresses and control bits
`default_nettype none

package regmap_pkg;

  typedef logic [15:0] word_t;      // One bus and memory word
  typedef logic [9:0]  bus_addr_t;  // CPU address, top bit picks the delay memory
  typedef logic [8:0]  ram_addr_t;  // Register memory address

  localparam int bus_dly_sel_bit = 9;
  localparam int ram_rd_latency  = 2;  // Address in to data out, in cycles

  localparam logic [7:0] version_num  = 8'h87;
  localparam logic [7:0] feature_bits = 8'h00;
  localparam word_t      version_word = {feature_bits, version_num};

  // ##################################################
  // Register addresses
  localparam ram_addr_t addr_ctl_reg          = 9'h000;
  localparam ram_addr_t addr_fpga_info        = 9'h001;
  localparam ram_addr_t addr_ec_sync_time_0   = 9'h011;
  localparam ram_addr_t addr_ec_sync_time_1   = 9'h012;
  localparam ram_addr_t addr_ec_sync_time_2   = 9'h013;
  localparam ram_addr_t addr_ec_sync_time_3   = 9'h014;
  localparam ram_addr_t addr_mod_cycle        = 9'h020;
  localparam ram_addr_t addr_mod_freq_div_0   = 9'h021;
  localparam ram_addr_t addr_mod_freq_div_1   = 9'h022;
  localparam ram_addr_t addr_version          = 9'h03f;
  localparam ram_addr_t addr_silent_cycle     = 9'h040;
  localparam ram_addr_t addr_silent_step      = 9'h041;
  localparam ram_addr_t addr_stm_cycle        = 9'h050;
  localparam ram_addr_t addr_stm_freq_div_0   = 9'h051;
  localparam ram_addr_t addr_stm_freq_div_1   = 9'h052;
  localparam ram_addr_t addr_sound_speed_0    = 9'h053;
  localparam ram_addr_t addr_sound_speed_1    = 9'h054;
  localparam ram_addr_t addr_cycle_base       = 9'h100;  // One word per transducer

  // ##################################################
  // Bits of the control word
  localparam int ctl_legacy_mode_bit   = 0;
  localparam int ctl_force_fan_bit     = 4;
  localparam int ctl_op_mode_bit       = 5;
  localparam int ctl_stm_gain_mode_bit = 6;
  localparam int ctl_sync_bit          = 8;

endpackage

`default_nettype wire

//--- tb.f
logic/regmap_pkg.sv
logic/array_pkg.sv
logic/dual_port_ram.sv
logic/param_controller.sv
logic/delay_mirror.sv
logic/array_ctl_top.sv
tests/tb_array_ctl.sv

//--- tests/tb_array_ctl.sv
// Directed testbench for the array control top covering settings, status, sync and delays
`default_nettype none
`timescale 1ns/1ps

module tb_array_ctl import regmap_pkg::*, array_pkg::*; ();

  localparam int    max_cycles   = 4000;
  localparam int    setting_wait = 26;
  localparam int    sync_bound   = 12 + 8 + num_trans + 4;
  localparam int    delay_wait   = 2 * num_trans + 4;
  localparam word_t sync_mask    = word_t'(1) << ctl_sync_bit;
  localparam word_t mode_mask    = (word_t'(1) << ctl_legacy_mode_bit)
                                 | (word_t'(1) << ctl_force_fan_bit)
                                 | (word_t'(1) << ctl_op_mode_bit)
                                 | (word_t'(1) << ctl_stm_gain_mode_bit);

  logic        CLK = 1'b0;
  logic        reset;
  logic        thermo;
  logic        bus_en;
  logic        bus_we;
  bus_addr_t   bus_addr;
  word_t       bus_wdata;
  word_t       bus_rdata;
  logic        force_fan;
  logic        op_mode;
  logic        stm_gain_mode;
  logic        legacy_mode;
  word_t       cycle_m;
  logic [31:0] freq_div_m;
  word_t       cycle_s;
  cycle_t      step_s;
  word_t       cycle_stm;
  logic [31:0] freq_div_stm;
  logic [31:0] sound_speed;
  logic [63:0] ecat_sync_time;
  logic        sync_set;
  cycle_t      cycle [num_trans];
  delay_t      delay_m [num_trans];

  int          errors     = 0;
  int          tests_run  = 0;
  int          cycle_cnt  = 0;
  logic [31:0] rng        = 32'h5aad2ac3;
  word_t       ctl_shadow = '0;  // Control word last written by the host

  array_ctl_top UUT (.*);

  initial begin
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout, run stopped after %0d cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // ##################################################
  // Helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    $display("%s: %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
  endtask

  task automatic bus_write(input bus_addr_t addr, input word_t data);
    bus_en    = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge CLK);
    bus_en = 1'b0;
    bus_we = 1'b0;
  endtask

  task automatic bus_read(input bus_addr_t addr, output word_t data);
    bus_en   = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    @(negedge CLK);
    bus_en = 1'b0;
    @(negedge CLK);  // Address and output registers
    data = bus_rdata;
  endtask

  task automatic check_modes(input word_t ctl);
    check("legacy_mode", legacy_mode, ctl[ctl_legacy_mode_bit]);
    check("force_fan", force_fan, ctl[ctl_force_fan_bit]);
    check("op_mode", op_mode, ctl[ctl_op_mode_bit]);
    check("stm_gain_mode", stm_gain_mode, ctl[ctl_stm_gain_mode_bit]);
  endtask

  // ##################################################
  // Tests
  task automatic reset_values();
    word_t r;
    int    err0;
    err0 = errors;
    check("sync_set", sync_set, 0);
    check_modes('0);
    check("cycle_m", cycle_m, 0);
    check("ecat_sync_time", ecat_sync_time, 0);
    check("delay_m[0]", delay_m[0], 0);
    repeat (4) @(negedge CLK);
    bus_read(addr_version, r);
    check("version", r, version_word);
    report_test("reset_values", err0);
  endtask

  task automatic setting_refresh();
    word_t w [10];
    int    err0;
    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      rng  = xorshift32(rng);
      w[i] = rng[15:0];
    end
    bus_write(addr_mod_cycle, w[0]);
    bus_write(addr_mod_freq_div_0, w[1]);
    bus_write(addr_mod_freq_div_1, w[2]);
    bus_write(addr_silent_cycle, w[3]);
    bus_write(addr_silent_step, w[4]);
    bus_write(addr_stm_cycle, w[5]);
    bus_write(addr_stm_freq_div_0, w[6]);
    bus_write(addr_stm_freq_div_1, w[7]);
    bus_write(addr_sound_speed_0, w[8]);
    bus_write(addr_sound_speed_1, w[9]);
    repeat (setting_wait) @(negedge CLK);
    check("cycle_m", cycle_m, w[0]);
    check("freq_div_m", freq_div_m, {w[2], w[1]});
    check("cycle_s", cycle_s, w[3]);
    check("step_s", step_s, w[4][$bits(cycle_t)-1:0]);
    check("cycle_stm", cycle_stm, w[5]);
    check("freq_div_stm", freq_div_stm, {w[7], w[6]});
    check("sound_speed", sound_speed, {w[9], w[8]});
    // Random pattern and then its complement give every mode bit both values
    rng        = xorshift32(rng);
    ctl_shadow = rng[15:0] & mode_mask;
    for (int k = 0; k < 2; k++) begin
      bus_write(addr_ctl_reg, ctl_shadow);
      repeat (setting_wait) @(negedge CLK);
      check_modes(ctl_shadow);
      if (k == 0) begin
        ctl_shadow = ctl_shadow ^ mode_mask;
      end
    end
    report_test("settings", err0);
  endtask

  task automatic thermo_readback();
    word_t r;
    int    err0;
    err0 = errors;
    for (int k = 1; k >= 0; k--) begin
      thermo = k[0];
      repeat (setting_wait) @(negedge CLK);
      bus_read(addr_fpga_info, r);
      check("fpga_info", r, word_t'(k[0]));
    end
    report_test("thermo", err0);
  endtask

  task automatic sync_sequence();
    word_t ts [4];
    word_t cw [num_trans];
    word_t r;
    int    n;
    int    err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      rng   = xorshift32(rng);
      ts[i] = rng[15:0];
    end
    bus_write(addr_ec_sync_time_0, ts[0]);
    bus_write(addr_ec_sync_time_1, ts[1]);
    bus_write(addr_ec_sync_time_2, ts[2]);
    bus_write(addr_ec_sync_time_3, ts[3]);
    for (int i = 0; i < num_trans; i++) begin
      rng   = xorshift32(rng);
      cw[i] = rng[15:0];
      bus_write(bus_addr_t'(addr_cycle_base + i), cw[i]);
    end
    bus_write(addr_ctl_reg, ctl_shadow | sync_mask);
    n = 0;
    while (!sync_set && n < sync_bound) begin
      @(negedge CLK);
      n++;
    end
    if (!sync_set) begin
      $display("sync_set did not rise within %0d cycles of setting the sync bit", sync_bound);
      errors++;
    end else begin
      check("ecat_sync_time", ecat_sync_time, {ts[3], ts[2], ts[1], ts[0]});
      for (int i = 0; i < num_trans; i++) begin
        check($sformatf("cycle[%0d]", i), cycle[i], cw[i][$bits(cycle_t)-1:0]);
      end
      @(negedge CLK);
      check("sync_set", sync_set, 0);  // Single cycle pulse
      repeat (7) @(negedge CLK);
      bus_read(addr_ctl_reg, r);
      check("ctl_reg", r, ctl_shadow);
    end
    report_test("sync", err0);
  endtask

  task automatic delay_scan();
    delay_t exp_dly [num_trans];
    int     idx;
    int     err0;
    err0 = errors;
    for (int i = 0; i < num_trans; i++) begin
      rng        = xorshift32(rng);
      exp_dly[i] = rng[15:0];
      bus_write(bus_addr_t'((1 << bus_dly_sel_bit) | i), exp_dly[i]);
    end
    repeat (delay_wait) @(negedge CLK);
    for (int i = 0; i < num_trans; i++) begin
      check($sformatf("delay_m[%0d]", i), delay_m[i], exp_dly[i]);
    end
    rng          = xorshift32(rng);
    idx          = int'(rng[$bits(trans_idx_t)-1:0]);
    rng          = xorshift32(rng);
    exp_dly[idx] = exp_dly[idx] ^ (rng[15:0] | 16'h0001);  // Always a new value
    bus_write(bus_addr_t'((1 << bus_dly_sel_bit) | idx), exp_dly[idx]);
    repeat (delay_wait) @(negedge CLK);
    for (int i = 0; i < num_trans; i++) begin
      check($sformatf("delay_m[%0d]", i), delay_m[i], exp_dly[i]);
    end
    report_test("delays", err0);
  endtask

  // ##################################################
  // Main sequence
  initial begin
    reset     = 1'b1;
    thermo    = 1'b0;
    bus_en    = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    @(negedge CLK);
    bus_write(addr_ctl_reg, '0);  // Clear control word in the unreset register RAM
    repeat (14) @(negedge CLK);
    reset = 1'b0;
    reset_values();
    setting_refresh();
    thermo_readback();
    sync_sequence();
    delay_scan();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
